/* source/corr_ctrl_pkg.sv */
`default_nettype none

package corr_ctrl_pkg;

	localparam int cmd_width   = 8;
	localparam int op_width    = 4;
	localparam int slot_width  = 2;
	localparam int arg_width   = 4;
	localparam int line_width  = 8;
	localparam int lag_width   = 12;
	localparam int div_width   = 4;
	localparam int level_width = 8;

	typedef logic [cmd_width-1:0]   cmd_byte_t;
	typedef logic [line_width-1:0]  line_t;
	typedef logic [lag_width-1:0]   lag_t;
	typedef logic [div_width-1:0]   div_t;
	typedef logic [level_width-1:0] level_t;

	// 2, 10, 11, 14 and 15 have no meaning here
	typedef enum logic [op_width-1:0] {
		clear          = 4'd0,
		set_line       = 4'd1,
		set_baud       = 4'd3,
		set_delay      = 4'd4,  // 4..7, low bits are the slot
		set_freq_div   = 4'd8,
		set_voltage    = 4'd9,
		enable_test    = 4'd12,
		enable_capture = 4'd13
	} opcode_t;

	typedef struct packed {
		opcode_t               op;
		logic [slot_width-1:0] slot;
		logic [arg_width-1:0]  arg;   // high nibble of the byte
	} dec_cmd_t;

	typedef struct packed {
		lag_t   cross_idx;
		lag_t   auto_idx;
		lag_t   cross_len;
		lag_t   auto_len;
		div_t   cross_div;
		div_t   auto_div;
		div_t   cross_div_len;
		div_t   auto_div_len;
		level_t test;
		level_t voltage;
	} line_cfg_t;

	typedef struct packed {
		logic integrating;
		logic external_clock;
		logic timestamp_reset;
		logic extra_commands;   // selects len / div_len / high test nibble
	} ctrl_flags_t;

	localparam ctrl_flags_t flags_reset = '{
		integrating:     1'b0,
		external_clock:  1'b0,
		timestamp_reset: 1'b1,
		extra_commands:  1'b0
	};

endpackage

`default_nettype wire

/* source/cmd_decode.sv */
`default_nettype none

module cmd_decode (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cmd_valid,
	input  corr_ctrl_pkg::cmd_byte_t cmd,
	output logic                     dec_valid,
	output corr_ctrl_pkg::dec_cmd_t  dec
);
	import corr_ctrl_pkg::*;

	logic     known;
	dec_cmd_t dec_next;

	always_comb begin
		known         = 1'b1;
		dec_next.op   = clear;
		dec_next.slot = '0;
		dec_next.arg  = cmd[cmd_width-1:op_width];
		case (cmd[op_width-1:0])
			clear: begin
				dec_next.op = clear;
			end
			set_line: begin
				dec_next.op = set_line;
			end
			set_baud: begin
				dec_next.op = set_baud;
			end
			set_delay, 4'd5, 4'd6, 4'd7: begin
				dec_next.op   = set_delay;
				dec_next.slot = cmd[slot_width-1:0];   // 3-bit field index
			end
			set_freq_div: begin
				dec_next.op = set_freq_div;
			end
			set_voltage: begin
				dec_next.op = set_voltage;
			end
			enable_test: begin
				dec_next.op = enable_test;
			end
			enable_capture: begin
				dec_next.op = enable_capture;
			end
			default: begin
				known = 1'b0;   // dropped here
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cmd_valid && known;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			dec <= dec_next;
		end
	end

endmodule

`default_nettype wire

/* source/line_config.sv */
`default_nettype none

module line_config #(
	parameter int NUM_LINES = 8
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      dec_valid,
	input  corr_ctrl_pkg::dec_cmd_t                   dec,
	output corr_ctrl_pkg::line_cfg_t [NUM_LINES-1:0] cfg_bank,
	output corr_ctrl_pkg::line_t                      current_line,
	output corr_ctrl_pkg::ctrl_flags_t                flags,
	output corr_ctrl_pkg::div_t                       baud_rate
);
	import corr_ctrl_pkg::*;

	logic line_ok;
	logic line_write;

	function automatic line_cfg_t apply_cmd(
		input line_cfg_t cfg,
		input dec_cmd_t  d,
		input logic      x
	);
		line_cfg_t nxt;
		nxt = cfg;
		case (d.op)
			clear: begin
				nxt.cross_idx = '0;
				nxt.auto_idx  = '0;
			end
			set_delay: begin
				case ({d.arg[3], x})
					2'b00: nxt.cross_idx[d.slot*3 +: 3] = d.arg[2:0];
					2'b01: nxt.cross_len[d.slot*3 +: 3] = d.arg[2:0];
					2'b10: nxt.auto_idx[d.slot*3 +: 3]  = d.arg[2:0];
					default: nxt.auto_len[d.slot*3 +: 3] = d.arg[2:0];
				endcase
			end
			set_freq_div: begin
				case ({d.arg[3], x})
					2'b00: nxt.cross_div[d.arg[2]*2 +: 2]     = d.arg[1:0];
					2'b01: nxt.cross_div_len[d.arg[2]*2 +: 2] = d.arg[1:0];
					2'b10: nxt.auto_div[d.arg[2]*2 +: 2]      = d.arg[1:0];
					default: nxt.auto_div_len[d.arg[2]*2 +: 2] = d.arg[1:0];
				endcase
			end
			set_voltage: begin
				nxt.voltage[d.arg[3:2]*2 +: 2] = d.arg[1:0];
			end
			enable_test: begin
				nxt.test[x*4 +: 4] = d.arg;   // high nibble when x set
			end
			default: begin
				nxt = cfg;
			end
		endcase
		return nxt;
	endfunction

	assign line_ok = 32'(current_line) < NUM_LINES;

	always_comb begin
		case (dec.op)
			clear, set_delay, set_freq_div, set_voltage, enable_test: begin
				line_write = dec_valid && line_ok;
			end
			default: begin
				line_write = 1'b0;   // global or nothing
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_bank <= '0;
		end else if (line_write) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				if (current_line == line_t'(i)) begin
					cfg_bank[i] <= apply_cmd(cfg_bank[i], dec, flags.extra_commands);
				end
			end
		end
	end

	// global registers
	always_ff @(posedge clk) begin
		if (reset) begin
			current_line <= '0;
			flags        <= flags_reset;
			baud_rate    <= '0;
		end else if (dec_valid) begin
			case (dec.op)
				set_line: begin
					current_line[dec.arg[3:2]*2 +: 2] <= dec.arg[1:0];   // built two bits at a time
				end
				set_baud: begin
					baud_rate <= dec.arg;
				end
				enable_capture: begin
					flags.integrating     <= dec.arg[0];
					flags.external_clock  <= dec.arg[1];
					flags.timestamp_reset <= dec.arg[2];
					flags.extra_commands  <= dec.arg[3];
				end
				default: begin
					current_line <= current_line;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/pwm_bank.sv */
`default_nettype none

module pwm_bank #(
	parameter int NUM_LINES = 8
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  corr_ctrl_pkg::line_cfg_t [NUM_LINES-1:0] cfg_bank,
	input  corr_ctrl_pkg::line_t                     read_line,
	output logic [NUM_LINES-1:0]                     pwm,
	output corr_ctrl_pkg::line_cfg_t                 line_cfg
);
	import corr_ctrl_pkg::*;

	level_t    pwm_count;
	line_cfg_t read_cfg;

	// shared across lines, wraps every 256 cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			pwm_count <= '0;
		end else begin
			pwm_count <= pwm_count + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LINES; i++) begin
			pwm[i] = pwm_count < cfg_bank[i].voltage;   // voltage 0 never high
		end
	end

	always_comb begin
		read_cfg = '0;   // unmatched line reads zero
		for (int i = 0; i < NUM_LINES; i++) begin
			if (read_line == line_t'(i)) begin
				read_cfg = cfg_bank[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		line_cfg <= read_cfg;
	end

endmodule

`default_nettype wire

/* source/corr_ctrl_top.sv */
`default_nettype none

module corr_ctrl_top #(
	parameter int NUM_LINES = 8
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       cmd_valid,
	input  corr_ctrl_pkg::cmd_byte_t   cmd,
	input  corr_ctrl_pkg::line_t       read_line,
	output logic [NUM_LINES-1:0]       pwm,
	output corr_ctrl_pkg::line_cfg_t   line_cfg,
	output corr_ctrl_pkg::line_t       current_line,
	output corr_ctrl_pkg::ctrl_flags_t flags,
	output corr_ctrl_pkg::div_t        baud_rate
);
	import corr_ctrl_pkg::*;

	logic                        dec_valid;
	dec_cmd_t                    dec;
	line_cfg_t [NUM_LINES-1:0]   cfg_bank;

	cmd_decode cmd_decode_i (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	line_config #(
		.NUM_LINES (NUM_LINES)
	) line_config_i (
		.clk          (clk),
		.reset        (reset),
		.dec_valid    (dec_valid),
		.dec          (dec),
		.cfg_bank     (cfg_bank),
		.current_line (current_line),
		.flags        (flags),
		.baud_rate    (baud_rate)
	);

	// pwm outputs and line readback
	pwm_bank #(
		.NUM_LINES (NUM_LINES)
	) pwm_bank_i (
		.clk       (clk),
		.reset     (reset),
		.cfg_bank  (cfg_bank),
		.read_line (read_line),
		.pwm       (pwm),
		.line_cfg  (line_cfg)
	);

endmodule

`default_nettype wire

/* tb/corr_ctrl_checker.sv */
`default_nettype none

module corr_ctrl_checker #(
	parameter int NUM_LINES = 8
) (
	input logic                                     clk,
	input logic                                     reset,
	input logic                                     cmd_valid,
	input corr_ctrl_pkg::cmd_byte_t                 cmd,
	input logic                                     dec_valid,
	input corr_ctrl_pkg::line_cfg_t [NUM_LINES-1:0] cfg_bank,
	input logic [NUM_LINES-1:0]                     pwm
);
	timeunit 1ns;
	timeprecision 1ps;

	logic                 known;
	logic [NUM_LINES-1:0] zero_voltage;

	always_comb begin
		case (cmd[3:0])
			4'd2, 4'd10, 4'd11, 4'd14, 4'd15: known = 1'b0;
			default: known = 1'b1;
		endcase
	end

	always_comb begin
		for (int i = 0; i < NUM_LINES; i++)
			zero_voltage[i] = cfg_bank[i].voltage == '0;
	end

	decode_follows: assert property (@(posedge clk) disable iff (reset)
		cmd_valid && known |=> dec_valid)
		else $error("known command gave no dec_valid one cycle later");

	decode_quiet: assert property (@(posedge clk) disable iff (reset)
		!(cmd_valid && known) |=> !dec_valid)
		else $error("dec_valid without a known command the cycle before");

	pwm_off_at_zero: assert property (@(posedge clk) (pwm & zero_voltage) == '0)
		else $error("pwm high on a line with zero voltage");

	pwm_off_in_reset: assert property (@(posedge clk) reset |=> pwm == '0)
		else $error("pwm active during reset");

endmodule

bind corr_ctrl_top corr_ctrl_checker #(
	.NUM_LINES (NUM_LINES)
) checker_i (
	.clk       (clk),
	.reset     (reset),
	.cmd_valid (cmd_valid),
	.cmd       (cmd),
	.dec_valid (dec_valid),
	.cfg_bank  (cfg_bank),
	.pwm       (pwm)
);

`default_nettype wire

/* tb/corr_ctrl_tb.sv */
`default_nettype none

module corr_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import corr_ctrl_pkg::*;

	localparam int num_lines      = 8;
	localparam int timeout_cycles = 6000;   // tests need under 1000 cycles

	logic                 clk;
	logic                 reset;
	logic                 cmd_valid;
	cmd_byte_t            cmd;
	line_t                read_line;
	logic [num_lines-1:0] pwm;
	line_cfg_t            line_cfg;
	line_t                current_line;
	ctrl_flags_t          flags;
	div_t                 baud_rate;

	// reference model
	line_cfg_t   model_cfg [num_lines];
	line_t       model_line;
	ctrl_flags_t model_flags;
	div_t        model_baud;

	integer seed;
	int     cycle_count = 0;

	corr_ctrl_top #(
		.NUM_LINES (num_lines)
	) corr_ctrl_top_i (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.read_line    (read_line),
		.pwm          (pwm),
		.line_cfg     (line_cfg),
		.current_line (current_line),
		.flags        (flags),
		.baud_rate    (baud_rate)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("Test failed");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	function automatic logic [31:0] put_bits(input logic [31:0] v, input int lsb,
			input int width, input logic [31:0] bits);
		logic [31:0] mask;
		mask = ((32'd1 << width) - 32'd1) << lsb;
		return (v & ~mask) | ((bits << lsb) & mask);
	endfunction

	task automatic model_apply(input cmd_byte_t b);
		logic [3:0] op;
		logic [3:0] arg;
		logic       x;
		logic       line_ok;
		int         n;
		int         lsb;
		op      = b[3:0];
		arg     = b[7:4];
		x       = model_flags.extra_commands;
		line_ok = int'(model_line) < num_lines;
		n       = int'(model_line);
		case (op)
			4'd0: begin
				if (line_ok) begin
					model_cfg[n].cross_idx = '0;
					model_cfg[n].auto_idx  = '0;
				end
			end
			4'd1: begin
				model_line = line_t'(put_bits(model_line, 2 * int'(arg[3:2]), 2, arg[1:0]));
			end
			4'd3: begin
				model_baud = arg;
			end
			4'd4, 4'd5, 4'd6, 4'd7: begin
				lsb = 3 * int'(op[1:0]);   // slot from opcode
				if (line_ok) begin
					if (!arg[3] && !x)
						model_cfg[n].cross_idx =
							lag_t'(put_bits(model_cfg[n].cross_idx, lsb, 3, arg[2:0]));
					else if (!arg[3] && x)
						model_cfg[n].cross_len =
							lag_t'(put_bits(model_cfg[n].cross_len, lsb, 3, arg[2:0]));
					else if (arg[3] && !x)
						model_cfg[n].auto_idx =
							lag_t'(put_bits(model_cfg[n].auto_idx, lsb, 3, arg[2:0]));
					else
						model_cfg[n].auto_len =
							lag_t'(put_bits(model_cfg[n].auto_len, lsb, 3, arg[2:0]));
				end
			end
			4'd8: begin
				lsb = 2 * int'(arg[2]);
				if (line_ok) begin
					if (!arg[3] && !x)
						model_cfg[n].cross_div =
							div_t'(put_bits(model_cfg[n].cross_div, lsb, 2, arg[1:0]));
					else if (!arg[3] && x)
						model_cfg[n].cross_div_len =
							div_t'(put_bits(model_cfg[n].cross_div_len, lsb, 2, arg[1:0]));
					else if (arg[3] && !x)
						model_cfg[n].auto_div =
							div_t'(put_bits(model_cfg[n].auto_div, lsb, 2, arg[1:0]));
					else
						model_cfg[n].auto_div_len =
							div_t'(put_bits(model_cfg[n].auto_div_len, lsb, 2, arg[1:0]));
				end
			end
			4'd9: begin
				lsb = 2 * int'(arg[3:2]);
				if (line_ok)
					model_cfg[n].voltage =
						level_t'(put_bits(model_cfg[n].voltage, lsb, 2, arg[1:0]));
			end
			4'd12: begin
				lsb = x ? 4 : 0;   // high nibble with extra_commands
				if (line_ok)
					model_cfg[n].test = level_t'(put_bits(model_cfg[n].test, lsb, 4, arg));
			end
			4'd13: begin
				model_flags.integrating     = arg[0];
				model_flags.external_clock  = arg[1];
				model_flags.timestamp_reset = arg[2];
				model_flags.extra_commands  = arg[3];
			end
			default: begin
				// 2, 10, 11, 14 and 15 are ignored
			end
		endcase
	endtask

	// called on a falling edge, returns on the next one
	task automatic send_cmd(input cmd_byte_t b);
		cmd_valid = 1'b1;
		cmd       = b;
		model_apply(b);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic settle();
		repeat (2) @(negedge clk);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic read_back_line(input line_t n);
		line_cfg_t exp;
		exp       = (int'(n) < num_lines) ? model_cfg[n] : '0;
		read_line = n;
		@(negedge clk);   // line_cfg is registered
		compare_value($sformatf("line%0d.cross_idx", n), exp.cross_idx, line_cfg.cross_idx);
		compare_value($sformatf("line%0d.auto_idx", n), exp.auto_idx, line_cfg.auto_idx);
		compare_value($sformatf("line%0d.cross_len", n), exp.cross_len, line_cfg.cross_len);
		compare_value($sformatf("line%0d.auto_len", n), exp.auto_len, line_cfg.auto_len);
		compare_value($sformatf("line%0d.cross_div", n), exp.cross_div, line_cfg.cross_div);
		compare_value($sformatf("line%0d.auto_div", n), exp.auto_div, line_cfg.auto_div);
		compare_value($sformatf("line%0d.cross_div_len", n), exp.cross_div_len,
			line_cfg.cross_div_len);
		compare_value($sformatf("line%0d.auto_div_len", n), exp.auto_div_len,
			line_cfg.auto_div_len);
		compare_value($sformatf("line%0d.test", n), exp.test, line_cfg.test);
		compare_value($sformatf("line%0d.voltage", n), exp.voltage, line_cfg.voltage);
	endtask

	task automatic verify_globals();
		compare_value("current_line", model_line, current_line);
		compare_value("flags", model_flags, flags);
		compare_value("baud_rate", model_baud, baud_rate);
	endtask

	task automatic select_line(input line_t n);
		for (int p = 0; p < 4; p++)
			send_cmd({2'(p), 2'(n >> (2 * p)), 4'h1});
	endtask

	task automatic set_capture(input logic [3:0] arg);
		send_cmd({arg, 4'hD});
	endtask

	task automatic set_line_voltage(input line_t n, input level_t v);
		select_line(n);
		for (int p = 0; p < 4; p++)
			send_cmd({2'(p), 2'(v >> (2 * p)), 4'h9});
	endtask

	task automatic reset_state_check();
		compare_value("pwm", '0, pwm);
		verify_globals();
		for (int n = 0; n <= num_lines; n++)
			read_back_line(line_t'(n));
	endtask

	// every delay slot and divider half, both sides, both banks
	task automatic program_line(input line_t n);
		int val;
		select_line(n);
		for (int x = 0; x < 2; x++) begin
			set_capture({1'(x), 3'b100});
			for (int slot = 0; slot < 4; slot++) begin
				for (int side = 0; side < 2; side++) begin
					val = slot + 2 * side + 3 * x + int'(n);
					send_cmd({1'(side), 3'(val), 2'b01, 2'(slot)});
				end
			end
			for (int half = 0; half < 2; half++) begin
				for (int side = 0; side < 2; side++) begin
					val = half + 2 * side + x + 1;
					send_cmd({1'(side), 1'(half), 2'(val), 4'h8});
				end
			end
			settle();
			read_back_line(n);
		end
		verify_globals();
	endtask

	task automatic delay_and_divider();
		program_line(8'd5);
		program_line(8'd2);
		select_line(8'd2);
		send_cmd(8'hF0);   // clear ignores its arg
		settle();
		read_back_line(8'd2);
		read_back_line(8'd5);
	endtask

	task automatic random_stream();
		repeat (200)
			send_cmd(cmd_byte_t'($random(seed)));
		settle();
		for (int n = 0; n <= num_lines; n++)
			read_back_line(line_t'(n));
		read_back_line(8'hFF);
		verify_globals();
	endtask

	task automatic pwm_duty_cycle();
		int high_0;
		int high_3;
		int high_7;
		set_line_voltage(8'd0, 8'd0);
		set_line_voltage(8'd3, 8'd64);
		set_line_voltage(8'd7, 8'd255);
		settle();
		high_0 = 0;
		high_3 = 0;
		high_7 = 0;
		repeat (256) begin
			if (pwm[0]) high_0++;
			if (pwm[3]) high_3++;
			if (pwm[7]) high_7++;
			@(negedge clk);
		end
		compare_value("pwm[0] high cycles", 0, high_0);
		compare_value("pwm[3] high cycles", 64, high_3);
		compare_value("pwm[7] high cycles", 255, high_7);
	endtask

	task automatic flags_and_baud();
		select_line(8'd4);
		set_capture(4'b0100);
		send_cmd({4'hA, 4'hC});   // low test nibble
		set_capture(4'b1100);
		send_cmd({4'h5, 4'hC});   // high test nibble
		send_cmd({4'h9, 4'h3});
		settle();
		read_back_line(8'd4);
		verify_globals();
		set_capture(4'b0011);
		settle();
		verify_globals();
		set_capture(4'b1010);
		settle();
		verify_globals();
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		read_line = '0;
		seed      = 32'hccfdfe19;
		for (int i = 0; i < num_lines; i++)
			model_cfg[i] = '0;
		model_line  = '0;
		model_flags = '{integrating: 1'b0, external_clock: 1'b0, timestamp_reset: 1'b1,
			extra_commands: 1'b0};
		model_baud  = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		reset_state_check();
		delay_and_divider();
		random_stream();
		pwm_duty_cycle();
		flags_and_baud();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/corr_ctrl_pkg.sv
source/cmd_decode.sv
source/line_config.sv
source/pwm_bank.sv
source/corr_ctrl_top.sv
tb/corr_ctrl_checker.sv
tb/corr_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the correlator command testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module corr_ctrl_tb -f filelist.f -o corr_ctrl_sim

if ./obj_dir/corr_ctrl_sim | tee /dev/stderr | grep "Test completed successfully" > /dev/null; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
